// File: dv/spi_clkgen.sv
/*
 * testbench clock and reset generator
 * 4 ns clock, nreset held low for the first 10 cycles
 */

`timescale 1ns/100ps

module spi_clkgen
(
   output logic clk,
   output logic nreset
);

   initial
   begin
      clk    = 1'b0;
      nreset = 1'b0;                   // reset from time 0
      repeat (10) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;                   // release away from the sampling edge
   end

   always #2 clk = ~clk;               // 250 MHz

endmodule

// File: dv/spi_master_tb.sv
/*
 * spi master testbench
 * table-driven register and loopback tests, miso tied to mosi
 */

`timescale 1ns/100ps

module spi_master_tb;

   localparam int n_entries   = 8;
   localparam int max_div     = 7;     // largest clkdiv in the table
   // table transfers plus the masked one, register traffic, reset and margin
   localparam int cycle_limit = (n_entries + 1) * (16 * (max_div + 1) + 64) + 400;

   logic                   clk;
   logic                   nreset;
   logic                   hw_en;
   logic                   access_in;
   logic                   miso;
   logic [spi_pkg::pw-1:0] packet_in;
   logic                   access_out;
   logic                   wait_out;
   logic                   irq;
   logic                   sclk;
   logic                   mosi;
   logic                   ss;
   logic [spi_pkg::pw-1:0] packet_out;

   // stimulus and expected values, one row per transfer
   logic        tbl_cpol [n_entries];
   logic        tbl_cpha [n_entries];
   logic        tbl_lsb  [n_entries];
   logic [7:0]  tbl_div  [n_entries];
   logic [7:0]  tbl_byte [n_entries];
   logic [31:0] tbl_rx0  [n_entries];
   logic [31:0] tbl_rx1  [n_entries];

   logic [31:0] lfsr_state;
   logic [63:0] model_hist;            // expected receive history
   int          cycles;

   spi_clkgen u_clkgen
   (
      .clk    (clk),
      .nreset (nreset)
   );

   assign miso = mosi;                 // loopback

   spi_master u_dut
   (
      .clk        (clk),
      .nreset     (nreset),
      .hw_en      (hw_en),
      .access_in  (access_in),
      .miso       (miso),
      .packet_in  (packet_in),
      .access_out (access_out),
      .wait_out   (wait_out),
      .irq        (irq),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss),
      .packet_out (packet_out)
   );

   // ####################################################################
   // helpers
   // ####################################################################

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] lfsr_take(input int nbits);
      logic [31:0] value;
      logic        fb;
      value = '0;
      for (int i = 0; i < nbits; i++)
      begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         value      = {value[30:0], fb};
      end
      return value;
   endfunction

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [spi_pkg::pw-1:0] make_packet(input logic write,
      input logic [31:0] dst, input logic [31:0] data, input logic [31:0] src,
      input logic [4:0] ctrl, input logic [1:0] dmode);
      logic [spi_pkg::pw-1:0] pkt;
      pkt                                          = '0;
      pkt[spi_pkg::write_lsb]                      = write;
      pkt[spi_pkg::datamode_lsb +: 2]              = dmode;
      pkt[spi_pkg::ctrlmode_lsb +: 5]              = ctrl;
      pkt[spi_pkg::dstaddr_lsb +: spi_pkg::aw]     = dst;
      pkt[spi_pkg::data_lsb +: spi_pkg::aw]        = data;
      pkt[spi_pkg::srcaddr_lsb +: spi_pkg::aw]     = src;
      return pkt;
   endfunction

   // one cycle strobe, called and returning on a falling edge
   task automatic send_packet(input logic [spi_pkg::pw-1:0] pkt);
      access_in = 1'b1;
      packet_in = pkt;
      @(negedge clk);
      access_in = 1'b0;
      packet_in = '0;
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
      send_packet(make_packet(1'b1, {26'h0, addr}, data, 32'h0, 5'h0, 2'h0));
   endtask

   // read with random return fields, response due one cycle later
   task automatic read_check(input string name, input logic [5:0] addr,
                             input logic [31:0] expected);
      logic [31:0]            src;
      logic [31:0]            rnd;
      logic [spi_pkg::pw-1:0] resp;
      src = lfsr_take(32);
      rnd = lfsr_take(7);              // ctrlmode, datamode
      check_equal({name, " access_out idle"}, 32'h0, 32'(access_out));
      send_packet(make_packet(1'b0, {26'h0, addr}, 32'h0, src, rnd[6:2], rnd[1:0]));
      check_equal({name, " access_out"}, 32'h1, 32'(access_out));
      resp = packet_out;
      check_equal({name, " write bit"}, 32'h1, 32'(resp[spi_pkg::write_lsb]));
      check_equal({name, " dstaddr"}, src, resp[spi_pkg::dstaddr_lsb +: 32]);
      check_equal({name, " srcaddr"}, 32'h0, resp[spi_pkg::srcaddr_lsb +: 32]);
      check_equal({name, " ctrlmode"}, 32'(rnd[6:2]), 32'(resp[spi_pkg::ctrlmode_lsb +: 5]));
      check_equal({name, " datamode"}, 32'(rnd[1:0]), 32'(resp[spi_pkg::datamode_lsb +: 2]));
      check_equal({name, " data"}, expected, resp[spi_pkg::data_lsb +: 32]);
      @(negedge clk);
      check_equal({name, " access_out pulse"}, 32'h0, 32'(access_out)); // single cycle
   endtask

   // one table row, expected history follows the shift rule
   task automatic set_entry(input int i, input logic cpol, input logic cpha,
                            input logic lsb, input logic [7:0] div);
      logic [31:0] rnd;
      rnd         = lfsr_take(8);
      tbl_cpol[i] = cpol;
      tbl_cpha[i] = cpha;
      tbl_lsb[i]  = lsb;
      tbl_div[i]  = div;
      tbl_byte[i] = rnd[7:0];
      model_hist  = {model_hist[55:0], rnd[7:0]};
      tbl_rx0[i]  = model_hist[31:0];
      tbl_rx1[i]  = model_hist[63:32];
   endtask

   task automatic fill_table;
      //        idx cpol cpha lsb  clkdiv
      set_entry(0, 1'b0, 1'b0, 1'b0, 8'd0);
      set_entry(1, 1'b1, 1'b0, 1'b0, 8'd1);
      set_entry(2, 1'b0, 1'b1, 1'b0, 8'd2);
      set_entry(3, 1'b1, 1'b1, 1'b0, 8'd3);
      set_entry(4, 1'b0, 1'b0, 1'b1, 8'd7);
      set_entry(5, 1'b1, 1'b0, 1'b1, 8'd0);
      set_entry(6, 1'b0, 1'b1, 1'b1, 8'd5);
      set_entry(7, 1'b1, 1'b1, 1'b1, 8'd1);
   endtask

   // ####################################################################
   // test sections
   // ####################################################################

   task automatic run_entry(input int i);
      string      tag;
      logic [7:0] cfg;
      logic       first_bit;
      tag = $sformatf("entry %0d", i);
      cfg = {3'b000, tbl_lsb[i], tbl_cpha[i], tbl_cpol[i], 2'b10}; // irq_en on
      first_bit = tbl_lsb[i] ? tbl_byte[i][0] : tbl_byte[i][7];
      write_reg(spi_pkg::reg_config, {24'hffffff, cfg});   // upper bits dropped
      write_reg(spi_pkg::reg_clkdiv, {24'h5a5a5a, tbl_div[i]});
      read_check({tag, " config"}, spi_pkg::reg_config, {24'h0, cfg});
      read_check({tag, " clkdiv"}, spi_pkg::reg_clkdiv, {24'h0, tbl_div[i]});
      check_equal({tag, " idle sclk"}, 32'(tbl_cpol[i]), 32'(sclk));
      check_equal({tag, " idle ss"}, 32'h1, 32'(ss));
      write_reg(spi_pkg::reg_tx, {24'h3c3c3c, tbl_byte[i]});
      check_equal({tag, " wait_out start"}, 32'h1, 32'(wait_out));
      check_equal({tag, " ss active"}, 32'h0, 32'(ss));
      check_equal({tag, " first mosi"}, 32'(first_bit), 32'(mosi)); // before any shift
      @(negedge clk);                  // status busy bit lags a cycle
      read_check({tag, " status busy"}, spi_pkg::reg_status, 32'h2);
      while (irq !== 1'b1)
         @(negedge clk);
      check_equal({tag, " wait_out done"}, 32'h0, 32'(wait_out));
      check_equal({tag, " ss released"}, 32'h1, 32'(ss));
      check_equal({tag, " sclk back idle"}, 32'(tbl_cpol[i]), 32'(sclk));
      read_check({tag, " status done"}, spi_pkg::reg_status, 32'h1);
      read_check({tag, " rx0"}, spi_pkg::reg_rx0, tbl_rx0[i]);
      read_check({tag, " rx1"}, spi_pkg::reg_rx1, tbl_rx1[i]);
      write_reg(spi_pkg::reg_status, 32'h0); // clear rx_done
      check_equal({tag, " irq cleared"}, 32'h0, 32'(irq));
      read_check({tag, " status cleared"}, spi_pkg::reg_status, 32'h0);
   endtask

   // transfer with irq_en low, irq must stay quiet
   task automatic masked_irq;
      logic [31:0] rnd;
      rnd        = lfsr_take(8);
      model_hist = {model_hist[55:0], rnd[7:0]};
      write_reg(spi_pkg::reg_config, 32'h0000000c); // cpol 1, cpha 1, irq_en 0
      write_reg(spi_pkg::reg_tx, {24'h0, rnd[7:0]});
      check_equal("masked wait_out start", 32'h1, 32'(wait_out));
      while (wait_out === 1'b1)
      begin
         check_equal("masked irq busy", 32'h0, 32'(irq));
         @(negedge clk);
      end
      @(negedge clk);                  // rx_done now set
      check_equal("masked irq done", 32'h0, 32'(irq));
      read_check("masked status", spi_pkg::reg_status, 32'h1);
      read_check("masked rx0", spi_pkg::reg_rx0, model_hist[31:0]);
      write_reg(spi_pkg::reg_config, 32'h0000000e); // irq_en back on
      check_equal("unmasked irq", 32'h1, 32'(irq));
      write_reg(spi_pkg::reg_status, 32'h0);
      check_equal("irq after clear", 32'h0, 32'(irq));
   endtask

   // transmit write that must be ignored
   task automatic check_dropped(input string name, input logic cpol);
      write_reg(spi_pkg::reg_tx, 32'h000000a5);
      repeat (20)
      begin
         check_equal({name, " wait_out"}, 32'h0, 32'(wait_out));
         check_equal({name, " sclk"}, 32'(cpol), 32'(sclk));
         check_equal({name, " ss"}, 32'h1, 32'(ss));
         @(negedge clk);
      end
      read_check({name, " rx0"}, spi_pkg::reg_rx0, model_hist[31:0]);
      read_check({name, " status"}, spi_pkg::reg_status, 32'h0);
   endtask

   // ####################################################################
   // main sequence
   // ####################################################################

   initial
   begin
      hw_en      = 1'b1;
      access_in  = 1'b0;
      packet_in  = '0;
      lfsr_state = 32'hde2923e9;
      model_hist = 64'h0;
      fill_table();
      wait (nreset === 1'b1);
      @(negedge clk);

      // reset values
      check_equal("reset access_out", 32'h0, 32'(access_out));
      check_equal("reset wait_out", 32'h0, 32'(wait_out));
      check_equal("reset irq", 32'h0, 32'(irq));
      check_equal("reset sclk", 32'h0, 32'(sclk));
      check_equal("reset ss", 32'h1, 32'(ss));
      read_check("reset config", spi_pkg::reg_config, 32'h0);
      read_check("reset status", spi_pkg::reg_status, 32'h0);
      read_check("reset clkdiv", spi_pkg::reg_clkdiv, 32'h1);
      read_check("reset rx0", spi_pkg::reg_rx0, 32'h0);
      read_check("unmapped", 6'h3c, 32'hdeadbeef);

      for (int i = 0; i < n_entries; i++)
         run_entry(i);

      masked_irq();

      // disable bit, then the enable pin
      write_reg(spi_pkg::reg_config, 32'h00000007); // disable, irq_en, cpol 1
      check_dropped("disable bit", 1'b1);
      write_reg(spi_pkg::reg_config, 32'h00000006);
      hw_en = 1'b0;
      check_dropped("hw_en low", 1'b1);
      hw_en = 1'b1;

      // manual slave select
      write_reg(spi_pkg::reg_config, 32'h00000020);
      check_equal("manual ss low", 32'h0, 32'(ss));
      check_equal("manual ss idle", 32'h0, 32'(wait_out));
      write_reg(spi_pkg::reg_config, 32'h00000000);
      check_equal("manual ss released", 32'h1, 32'(ss));

      $display("all tests passed");
      $finish;
   end

   // run length guard
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit)
      begin
         $display("timeout, run went past %0d cycles", cycle_limit);
         $display("tests failed");
         $fatal(1, "simulation timeout");
      end
   end

   initial cycles = 0;

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the spi master testbench with Verilator
# exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module spi_master_tb -o spi_master_sim \
   && ./obj_dir/spi_master_sim \
   || { echo "simulation run failed"; exit 1; }

// File: verilog/spi_master.sv
/*
 * spi master top
 * packet decode, register block, serial shifter and readback
 */

`timescale 1ns/100ps

module spi_master
(
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   hw_en,
   input  logic                   access_in,
   input  logic                   miso,
   input  logic [spi_pkg::pw-1:0] packet_in,
   output logic                   access_out,
   output logic                   wait_out,
   output logic                   irq,
   output logic                   sclk,
   output logic                   mosi,
   output logic                   ss,
   output logic [spi_pkg::pw-1:0] packet_out
);

   // decode outputs
   logic        reg_read;
   logic        config_write;
   logic        status_write;
   logic        clkdiv_write;
   logic        tx_write;
   logic [31:0] wdata;
   logic [5:0]  rd_addr;
   logic [31:0] srcaddr;
   logic [4:0]  ctrlmode;
   logic [1:0]  datamode;

   // register side
   logic        spi_en;
   logic        cpol;
   logic        cpha;
   logic        lsbfirst;
   logic        manual_ss;
   logic [7:0]  clkdiv;
   logic [7:0]  config_reg;
   logic [7:0]  status_reg;
   logic [63:0] rx_reg;

   // serial side
   logic        busy;
   logic        rx_access;
   logic [7:0]  rx_byte;

   assign wait_out = busy;             // transfer in flight

   // ####################################################################
   // stages
   // ####################################################################

   spi_packet_decode u_decode
   (
      .access_in    (access_in),
      .packet_in    (packet_in),
      .reg_read     (reg_read),
      .config_write (config_write),
      .status_write (status_write),
      .clkdiv_write (clkdiv_write),
      .tx_write     (tx_write),
      .wdata        (wdata),
      .rd_addr      (rd_addr),
      .srcaddr      (srcaddr),
      .ctrlmode     (ctrlmode),
      .datamode     (datamode)
   );

   spi_regs u_regs
   (
      .clk          (clk),
      .nreset       (nreset),
      .hw_en        (hw_en),
      .config_write (config_write),
      .status_write (status_write),
      .clkdiv_write (clkdiv_write),
      .wdata        (wdata),
      .busy         (busy),
      .rx_access    (rx_access),
      .rx_byte      (rx_byte),
      .spi_en       (spi_en),
      .cpol         (cpol),
      .cpha         (cpha),
      .lsbfirst     (lsbfirst),
      .manual_ss    (manual_ss),
      .irq          (irq),
      .clkdiv       (clkdiv),
      .config_reg   (config_reg),
      .status_reg   (status_reg),
      .rx_reg       (rx_reg)
   );

   spi_shifter u_shifter
   (
      .clk        (clk),
      .nreset     (nreset),
      .tx_write   (tx_write),
      .spi_en     (spi_en),
      .cpol       (cpol),
      .cpha       (cpha),
      .lsbfirst   (lsbfirst),
      .manual_ss  (manual_ss),
      .miso       (miso),
      .wdata_byte (wdata[7:0]),        // tx byte in the low data bits
      .clkdiv     (clkdiv),
      .busy       (busy),
      .rx_access  (rx_access),
      .sclk       (sclk),
      .mosi       (mosi),
      .ss         (ss),
      .rx_byte    (rx_byte)
   );

   spi_readback u_readback
   (
      .clk        (clk),
      .nreset     (nreset),
      .reg_read   (reg_read),
      .rd_addr    (rd_addr),
      .srcaddr    (srcaddr),
      .ctrlmode   (ctrlmode),
      .datamode   (datamode),
      .config_reg (config_reg),
      .status_reg (status_reg),
      .clkdiv_reg (clkdiv),
      .rx_reg     (rx_reg),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: verilog/spi_packet_decode.sv
/*
 * request packet decoder
 * slices the packet and raises one strobe per register access
 */

`timescale 1ns/100ps

module spi_packet_decode
(
   input  logic                   access_in,
   input  logic [spi_pkg::pw-1:0] packet_in,
   output logic                   reg_read,
   output logic                   config_write,
   output logic                   status_write,
   output logic                   clkdiv_write,
   output logic                   tx_write,
   output logic [31:0]            wdata,
   output logic [5:0]             rd_addr,
   output logic [31:0]            srcaddr,
   output logic [4:0]             ctrlmode,
   output logic [1:0]             datamode
);

   logic        write;                 // request is a write
   logic        reg_write;             // qualified write strobe
   logic [31:0] dstaddr;

   // ####################################################################
   // field extraction
   // ####################################################################

   assign write    = packet_in[spi_pkg::write_lsb];
   assign datamode = packet_in[spi_pkg::datamode_lsb +: 2];
   assign ctrlmode = packet_in[spi_pkg::ctrlmode_lsb +: 5];
   assign dstaddr  = packet_in[spi_pkg::dstaddr_lsb +: spi_pkg::aw];
   assign wdata    = packet_in[spi_pkg::data_lsb +: spi_pkg::aw];
   assign srcaddr  = packet_in[spi_pkg::srcaddr_lsb +: spi_pkg::aw];

   assign rd_addr  = dstaddr[5:0];     // only low offset bits decoded

   // ####################################################################
   // access strobes
   // ####################################################################

   assign reg_read  = access_in & ~write;
   assign reg_write = access_in & write;

   assign config_write = reg_write & (dstaddr[5:0] == spi_pkg::reg_config);
   assign status_write = reg_write & (dstaddr[5:0] == spi_pkg::reg_status);
   assign clkdiv_write = reg_write & (dstaddr[5:0] == spi_pkg::reg_clkdiv);
   assign tx_write     = reg_write & (dstaddr[5:0] == spi_pkg::reg_tx); // starts shifter

endmodule

// File: verilog/spi_pkg.sv
/*
 * spi master shared definitions
 * packet layout, register map, config/status bit positions, reset values
 */

package spi_pkg;

   // ####################################################################
   // packet layout
   // ####################################################################

   localparam int aw = 32;             // address and data width
   localparam int pw = 2*aw + 40;      // 104 bit request/response packet

   localparam int write_lsb    = 0;    // 1 = write
   localparam int datamode_lsb = 1;    // 2 bits
   localparam int ctrlmode_lsb = 3;    // 5 bits
   localparam int dstaddr_lsb  = 8;    // 32 bits
   localparam int data_lsb     = 40;   // 32 bits
   localparam int srcaddr_lsb  = 72;   // 32 bits

   // ####################################################################
   // register map, matched on dstaddr[5:0]
   // ####################################################################

   localparam logic [5:0] reg_config = 6'h00;
   localparam logic [5:0] reg_status = 6'h04;
   localparam logic [5:0] reg_clkdiv = 6'h08;
   localparam logic [5:0] reg_tx     = 6'h10;
   localparam logic [5:0] reg_rx0    = 6'h20; // newest four bytes
   localparam logic [5:0] reg_rx1    = 6'h24; // older four bytes

   // config bits
   localparam int cfg_disable   = 0;
   localparam int cfg_irq_en    = 1;
   localparam int cfg_cpol      = 2;
   localparam int cfg_cpha      = 3;
   localparam int cfg_lsbfirst  = 4;
   localparam int cfg_manual_ss = 5;

   // status bits
   localparam int st_rx_done = 0;     // sticky
   localparam int st_busy    = 1;

   localparam logic [7:0]  clkdiv_reset   = 8'd1;
   localparam logic [31:0] unmapped_rdata = 32'hdeadbeef;

endpackage

// File: verilog/spi_readback.sv
/*
 * spi readback stage
 * registered read mux and response packet to the requester
 */

`timescale 1ns/100ps

module spi_readback
(
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   reg_read,
   input  logic [5:0]             rd_addr,
   input  logic [31:0]            srcaddr,
   input  logic [4:0]             ctrlmode,
   input  logic [1:0]             datamode,
   input  logic [7:0]             config_reg,
   input  logic [7:0]             status_reg,
   input  logic [7:0]             clkdiv_reg,
   input  logic [63:0]            rx_reg,
   output logic                   access_out,
   output logic [spi_pkg::pw-1:0] packet_out
);

   logic [31:0] rdata_q;
   logic [31:0] dstaddr_q;             // return address
   logic [4:0]  ctrlmode_q;
   logic [1:0]  datamode_q;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= reg_read;       // one cycle read latency
   end

   // payload captured with the read
   always_ff @(posedge clk)
   begin
      if (reg_read)
      begin
         case (rd_addr)
            spi_pkg::reg_config : rdata_q <= {24'h0, config_reg};
            spi_pkg::reg_status : rdata_q <= {24'h0, status_reg};
            spi_pkg::reg_clkdiv : rdata_q <= {24'h0, clkdiv_reg};
            spi_pkg::reg_rx0    : rdata_q <= rx_reg[31:0];
            spi_pkg::reg_rx1    : rdata_q <= rx_reg[63:32];
            default             : rdata_q <= spi_pkg::unmapped_rdata;
         endcase
         dstaddr_q  <= srcaddr;
         ctrlmode_q <= ctrlmode;
         datamode_q <= datamode;
      end
   end

   // response is a write back, srcaddr left at zero
   always_comb
   begin
      packet_out                                         = '0;
      packet_out[spi_pkg::write_lsb]                     = 1'b1;
      packet_out[spi_pkg::datamode_lsb +: 2]             = datamode_q;
      packet_out[spi_pkg::ctrlmode_lsb +: 5]             = ctrlmode_q;
      packet_out[spi_pkg::dstaddr_lsb +: spi_pkg::aw]    = dstaddr_q;
      packet_out[spi_pkg::data_lsb +: spi_pkg::aw]       = rdata_q;
   end

endmodule

// File: verilog/spi_regs.sv
/*
 * spi register block
 * config, status, clock divider and the 64 bit receive history
 */

`timescale 1ns/100ps

module spi_regs
(
   input  logic        clk,
   input  logic        nreset,
   input  logic        hw_en,          // block enable pin
   input  logic        config_write,
   input  logic        status_write,
   input  logic        clkdiv_write,
   input  logic [31:0] wdata,
   input  logic        busy,           // from shifter
   input  logic        rx_access,      // end of transfer pulse
   input  logic [7:0]  rx_byte,
   output logic        spi_en,
   output logic        cpol,
   output logic        cpha,
   output logic        lsbfirst,
   output logic        manual_ss,
   output logic        irq,
   output logic [7:0]  clkdiv,
   output logic [7:0]  config_reg,
   output logic [7:0]  status_reg,
   output logic [63:0] rx_reg
);

   logic [1:0] status_q;               // busy, rx_done

   // ####################################################################
   // config
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         config_reg <= 8'h00;
      else if (config_write)
         config_reg <= wdata[7:0];
   end

   // control levels out of config
   assign spi_en    = hw_en & ~config_reg[spi_pkg::cfg_disable]; // on by default
   assign cpol      = config_reg[spi_pkg::cfg_cpol];
   assign cpha      = config_reg[spi_pkg::cfg_cpha];
   assign lsbfirst  = config_reg[spi_pkg::cfg_lsbfirst];
   assign manual_ss = config_reg[spi_pkg::cfg_manual_ss];

   // ####################################################################
   // status
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         status_q <= 2'b00;
      else if (status_write)
         status_q <= wdata[1:0];       // writing 0 clears rx_done
      else
      begin
         status_q[spi_pkg::st_busy]    <= busy;
         status_q[spi_pkg::st_rx_done] <= status_q[spi_pkg::st_rx_done] | rx_access;
      end
   end

   assign status_reg = {6'b000000, status_q};

   // level interrupt, held until rx_done cleared
   assign irq = config_reg[spi_pkg::cfg_irq_en] & status_q[spi_pkg::st_rx_done];

   // ####################################################################
   // clock divider
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         clkdiv <= spi_pkg::clkdiv_reset;
      else if (clkdiv_write)
         clkdiv <= wdata[7:0];
   end

   // receive history, newest byte in the low byte
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rx_reg <= 64'h0;
      else if (rx_access)
         rx_reg <= {rx_reg[55:0], rx_byte};
   end

endmodule

// File: verilog/spi_shifter.sv
/*
 * spi serial engine
 * one 8 bit transfer per start, all cpol/cpha modes, msb or lsb first
 */

`timescale 1ns/100ps

module spi_shifter
(
   input  logic       clk,
   input  logic       nreset,
   input  logic       tx_write,        // transmit register write
   input  logic       spi_en,
   input  logic       cpol,
   input  logic       cpha,
   input  logic       lsbfirst,
   input  logic       manual_ss,
   input  logic       miso,
   input  logic [7:0] wdata_byte,
   input  logic [7:0] clkdiv,
   output logic       busy,
   output logic       rx_access,       // one cycle, transfer done
   output logic       sclk,
   output logic       mosi,
   output logic       ss,
   output logic [7:0] rx_byte
);

   logic       start;                  // accepted transmit write
   logic       tick;                   // half period elapsed
   logic [7:0] div_cnt;
   logic [4:0] edge_cnt;               // sclk edges done, 0..16
   logic       last_edge;
   logic       sample_edge;            // capture miso on this edge
   logic       shift_edge;             // advance mosi on this edge
   logic       sclk_phase;             // 1 = sclk away from idle level
   logic [7:0] tx_sr;
   logic [7:0] rx_sr;

   // ####################################################################
   // timing
   // ####################################################################

   assign start = tx_write & spi_en & ~busy; // dropped otherwise
   assign tick  = busy & (div_cnt >= clkdiv); // >= survives a clkdiv change

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         div_cnt <= 8'd0;
      else if (start | tick)
         div_cnt <= 8'd0;
      else if (busy)
         div_cnt <= div_cnt + 8'd1;
   end

   assign last_edge = (edge_cnt == 5'd15);

   // odd edges sample for cpha 0, even edges for cpha 1
   assign sample_edge = tick & (edge_cnt[0] == cpha);
   // first cpha 1 edge only opens the bit
   assign shift_edge  = tick & (edge_cnt[0] != cpha) & (edge_cnt != 5'd0);

   // ####################################################################
   // transfer control
   // ####################################################################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         busy       <= 1'b0;
         rx_access  <= 1'b0;
         edge_cnt   <= 5'd0;
         sclk_phase <= 1'b0;
      end
      else
      begin
         rx_access <= tick & last_edge; // busy falls with it
         if (start)
         begin
            busy       <= 1'b1;
            edge_cnt   <= 5'd0;
            sclk_phase <= 1'b0;
         end
         else if (tick)
         begin
            edge_cnt   <= edge_cnt + 5'd1;
            sclk_phase <= ~sclk_phase;
            if (last_edge)
               busy <= 1'b0;
         end
      end
   end

   // ####################################################################
   // data path
   // ####################################################################

   // transmit shifter, first bit on mosi straight after load
   always_ff @(posedge clk)
   begin
      if (start)
         tx_sr <= wdata_byte;
      else if (shift_edge)
         tx_sr <= lsbfirst ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
   end

   // receive shifter, same direction so loopback returns the byte
   always_ff @(posedge clk)
   begin
      if (sample_edge)
         rx_sr <= lsbfirst ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
   end

   assign rx_byte = rx_sr;
   assign mosi    = lsbfirst ? tx_sr[0] : tx_sr[7];
   assign sclk    = cpol ^ sclk_phase; // idles at cpol
   assign ss      = ~(busy | manual_ss); // active low

endmodule

// File: vlog.f
verilog/spi_pkg.sv
verilog/spi_packet_decode.sv
verilog/spi_regs.sv
verilog/spi_shifter.sv
verilog/spi_readback.sv
verilog/spi_master.sv
dv/spi_clkgen.sv
dv/spi_master_tb.sv
